// File: source/ex_pkg.sv
package ex_pkg;

    ////////////////////
    // Widths and pipeline constants

    localparam int XLEN          = 64;
    localparam int WORD_BITS     = 32;
    localparam int INSTR_BYTES   = 4;
    localparam int SQUASH_CYCLES = 2;
    localparam int SQUASH_W      = $clog2(SQUASH_CYCLES + 1);

    ////////////////////
    // Operation encodings

    // Codes 13 to 15 are illegal
    typedef enum logic [3:0] {
        ALU_ADD      = 4'd0,
        ALU_SUB      = 4'd1,
        ALU_SLL      = 4'd2,
        ALU_SRL      = 4'd3,
        ALU_SRA      = 4'd4,
        ALU_XOR      = 4'd5,
        ALU_OR       = 4'd6,
        ALU_AND      = 4'd7,
        ALU_SLT      = 4'd8,
        ALU_SLTU     = 4'd9,
        ALU_PASS_A   = 4'd10,
        ALU_PASS_B   = 4'd11,
        ALU_A_PLUS_4 = 4'd12
    } alu_op_t;

    // Same as branch funct3
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_t;

    typedef enum logic [1:0] {BR_NONE, BR_COND, BR_JUMP} branch_kind_t;
    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_kind_t;
    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD, SIZE_DOUBLE} mem_size_t;

endpackage

// File: source/ex_alu.sv
`timescale 1ns/10ps

module ex_alu
    import ex_pkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic            in_valid,
    input  alu_op_t         alu_op,
    input  logic            op_32,
    input  logic [XLEN-1:0] operand_a,
    input  logic [XLEN-1:0] operand_b,
    input  mem_kind_t       mem_kind,
    input  mem_size_t       mem_size,
    output logic            alu_valid,
    output logic [XLEN-1:0] alu_result,
    output mem_kind_t       mem_kind_q,
    output mem_size_t       mem_size_q
);

    logic [5:0]           shamt;
    logic [WORD_BITS-1:0] add_w;
    logic [WORD_BITS-1:0] sub_w;
    logic [WORD_BITS-1:0] sll_w;
    logic [WORD_BITS-1:0] srl_w;
    logic [WORD_BITS-1:0] sra_w;
    logic [XLEN-1:0]      alu_next;

    function automatic logic [XLEN-1:0] sext_word(input logic [WORD_BITS-1:0] w);
        return {{(XLEN - WORD_BITS){w[WORD_BITS-1]}}, w};
    endfunction

    assign shamt = operand_b[5:0];

    // Word forms, low 5 bits of b as shift amount
    assign add_w = operand_a[WORD_BITS-1:0] + operand_b[WORD_BITS-1:0];
    assign sub_w = operand_a[WORD_BITS-1:0] - operand_b[WORD_BITS-1:0];
    assign sll_w = operand_a[WORD_BITS-1:0] << operand_b[4:0];
    assign srl_w = operand_a[WORD_BITS-1:0] >> operand_b[4:0];
    assign sra_w = $signed(operand_a[WORD_BITS-1:0]) >>> operand_b[4:0];

    always_comb
    begin
        case (alu_op)
            ALU_ADD:      alu_next = op_32 ? sext_word(add_w) : operand_a + operand_b;
            ALU_SUB:      alu_next = op_32 ? sext_word(sub_w) : operand_a - operand_b;
            ALU_SLL:      alu_next = op_32 ? sext_word(sll_w) : operand_a << shamt;
            ALU_SRL:      alu_next = op_32 ? sext_word(srl_w) : operand_a >> shamt;
            ALU_SRA:
            begin
                // Arithmetic shift, sign fills from the top
                if (op_32)
                    alu_next = sext_word(sra_w);
                else
                    alu_next = $signed(operand_a) >>> shamt;
            end
            ALU_XOR:      alu_next = operand_a ^ operand_b;
            ALU_OR:       alu_next = operand_a | operand_b;
            ALU_AND:      alu_next = operand_a & operand_b;
            ALU_SLT:      alu_next = {{(XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU:     alu_next = {{(XLEN-1){1'b0}}, operand_a < operand_b};
            ALU_PASS_A:   alu_next = operand_a;
            ALU_PASS_B:   alu_next = operand_b;
            ALU_A_PLUS_4: alu_next = operand_a + INSTR_BYTES;
            default:      alu_next = '0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RST)
            alu_valid <= 1'b0;
        else
            alu_valid <= in_valid;
    end

    always_ff @(posedge CLK)
    begin
        alu_result <= alu_next;
        mem_kind_q <= mem_kind;
        mem_size_q <= mem_size;
    end

    a_legal_op: assert property (@(posedge CLK) disable iff (RST)
        in_valid |-> alu_op <= ALU_A_PLUS_4)
        else $error("illegal alu_op code %0d", alu_op);

endmodule

// File: source/ex_branch.sv
`timescale 1ns/10ps

module ex_branch
    import ex_pkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic            in_valid,
    input  branch_kind_t    branch_kind,
    input  cmp_t            cond,
    input  logic [XLEN-1:0] cmp1,
    input  logic [XLEN-1:0] cmp2,
    input  logic [XLEN-1:0] jump_base,
    input  logic [XLEN-1:0] jump_offset,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] next_pc,
    output logic            br_valid,
    output logic [XLEN-1:0] resolved_pc,
    output logic [XLEN-1:0] next_pc_q
);

    logic            cond_true;
    logic            take;
    logic [XLEN-1:0] target;

    always_comb
    begin
        case (cond)
            CMP_BEQ:  cond_true = cmp1 == cmp2;
            CMP_BNE:  cond_true = cmp1 != cmp2;
            CMP_BLT:  cond_true = $signed(cmp1) < $signed(cmp2);
            CMP_BGE:  cond_true = $signed(cmp1) >= $signed(cmp2);
            CMP_BLTU: cond_true = cmp1 < cmp2;
            CMP_BGEU: cond_true = cmp1 >= cmp2;
            default:  cond_true = 1'b0;
        endcase
    end

    assign target = jump_base + jump_offset;
    assign take   = (branch_kind == BR_JUMP) || (branch_kind == BR_COND && cond_true);

    always_ff @(posedge CLK)
    begin
        if (RST)
            br_valid <= 1'b0;
        else
            br_valid <= in_valid;
    end

    // Fall-through resolves too, so kind none is checked against the prediction
    always_ff @(posedge CLK)
    begin
        resolved_pc <= take ? target : pc + INSTR_BYTES;
        next_pc_q   <= next_pc;
    end

    a_legal_cond: assert property (@(posedge CLK) disable iff (RST)
        in_valid && branch_kind == BR_COND |-> !(cond inside {3'd2, 3'd3}))
        else $error("unused branch condition code %0d", cond);

endmodule

// File: source/ex_redirect.sv
`timescale 1ns/10ps

module ex_redirect
    import ex_pkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic            br_valid,
    input  logic [XLEN-1:0] resolved_pc,
    input  logic [XLEN-1:0] next_pc_q,
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc,
    output logic            squash
);

    logic [SQUASH_W-1:0] squash_cnt;
    logic                mispredict;

    assign squash     = squash_cnt != '0;
    assign mispredict = br_valid && !squash && (resolved_pc != next_pc_q);

    ////////////////////
    // Redirect and squash window

    // Counter loads with the redirect and covers the two younger ops
    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            redirect   <= 1'b0;
            squash_cnt <= '0;
        end
        else
        begin
            redirect <= mispredict;
            if (mispredict)
                squash_cnt <= SQUASH_W'(SQUASH_CYCLES);
            else if (squash)
                squash_cnt <= squash_cnt - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        redirect_pc <= resolved_pc;
    end

    a_squash_window: assert property (@(posedge CLK) disable iff (RST)
        redirect |-> squash [*SQUASH_CYCLES] ##1 !squash)
        else $error("squash window did not last %0d cycles after a redirect", SQUASH_CYCLES);

endmodule

// File: source/ex_commit.sv
`timescale 1ns/10ps

module ex_commit
    import ex_pkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic            alu_valid,
    input  logic [XLEN-1:0] alu_result,
    input  mem_kind_t       mem_kind_q,
    input  mem_size_t       mem_size_q,
    input  logic            squash,
    output logic            result_valid,
    output logic [XLEN-1:0] result,
    output logic            mem_req,
    output logic            mem_write,
    output logic [XLEN-1:0] mem_addr,
    output mem_size_t       mem_size_out,
    output logic            misaligned
);

    logic take;
    logic is_mem;
    logic mis_next;

    assign take   = alu_valid && !squash;
    assign is_mem = (mem_kind_q == MEM_LOAD) || (mem_kind_q == MEM_STORE);

    // Crossing an 8-byte boundary
    always_comb
    begin
        case (mem_size_q)
            SIZE_HALF:   mis_next = &alu_result[2:0];
            SIZE_WORD:   mis_next = alu_result[2:0] > 3'd4;
            SIZE_DOUBLE: mis_next = |alu_result[2:0];
            default:     mis_next = 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            result_valid <= 1'b0;
            mem_req      <= 1'b0;
            misaligned   <= 1'b0;
        end
        else
        begin
            result_valid <= take;
            mem_req      <= take && is_mem && !mis_next;
            misaligned   <= take && is_mem && mis_next;
        end
    end

    always_ff @(posedge CLK)
    begin
        result       <= alu_result;
        mem_write    <= mem_kind_q == MEM_STORE;
        mem_addr     <= alu_result;
        mem_size_out <= mem_size_q;
    end

    a_mis_offset: assert property (@(posedge CLK) disable iff (RST)
        misaligned |-> mem_size_out != SIZE_BYTE && mem_addr[2:0] != 3'b000)
        else $error("misaligned flag on a byte or aligned access");

endmodule

// File: source/ex_stage.sv
`timescale 1ns/10ps

module ex_stage
    import ex_pkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic            in_valid,
    // ALU side
    input  alu_op_t         alu_op,
    input  logic            op_32,
    input  logic [XLEN-1:0] operand_a,
    input  logic [XLEN-1:0] operand_b,
    input  mem_kind_t       mem_kind,
    input  mem_size_t       mem_size,
    // Branch side
    input  branch_kind_t    branch_kind,
    input  cmp_t            cond,
    input  logic [XLEN-1:0] cmp1,
    input  logic [XLEN-1:0] cmp2,
    input  logic [XLEN-1:0] jump_base,
    input  logic [XLEN-1:0] jump_offset,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] next_pc,
    // Stage two outputs
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc,
    output logic            result_valid,
    output logic [XLEN-1:0] result,
    output logic            mem_req,
    output logic            mem_write,
    output logic [XLEN-1:0] mem_addr,
    output mem_size_t       mem_size_out,
    output logic            misaligned
);

    logic            alu_valid;
    logic [XLEN-1:0] alu_result;
    mem_kind_t       mem_kind_q;
    mem_size_t       mem_size_q;
    logic            br_valid;
    logic [XLEN-1:0] resolved_pc;
    logic [XLEN-1:0] next_pc_q;
    logic            squash;

    ////////////////////
    // Stage one

    ex_alu u_alu (
        .CLK        (CLK),
        .RST        (RST),
        .in_valid   (in_valid),
        .alu_op     (alu_op),
        .op_32      (op_32),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .mem_kind   (mem_kind),
        .mem_size   (mem_size),
        .alu_valid  (alu_valid),
        .alu_result (alu_result),
        .mem_kind_q (mem_kind_q),
        .mem_size_q (mem_size_q)
    );

    ex_branch u_branch (
        .CLK         (CLK),
        .RST         (RST),
        .in_valid    (in_valid),
        .branch_kind (branch_kind),
        .cond        (cond),
        .cmp1        (cmp1),
        .cmp2        (cmp2),
        .jump_base   (jump_base),
        .jump_offset (jump_offset),
        .pc          (pc),
        .next_pc     (next_pc),
        .br_valid    (br_valid),
        .resolved_pc (resolved_pc),
        .next_pc_q   (next_pc_q)
    );

    ////////////////////
    // Stage two

    ex_redirect u_redirect (
        .CLK         (CLK),
        .RST         (RST),
        .br_valid    (br_valid),
        .resolved_pc (resolved_pc),
        .next_pc_q   (next_pc_q),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .squash      (squash)
    );

    ex_commit u_commit (
        .CLK          (CLK),
        .RST          (RST),
        .alu_valid    (alu_valid),
        .alu_result   (alu_result),
        .mem_kind_q   (mem_kind_q),
        .mem_size_q   (mem_size_q),
        .squash       (squash),
        .result_valid (result_valid),
        .result       (result),
        .mem_req      (mem_req),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_size_out (mem_size_out),
        .misaligned   (misaligned)
    );

endmodule

// File: verification/ex_checker.sv
`timescale 1ns/10ps

module ex_checker
    import ex_pkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic            in_valid,
    input  alu_op_t         alu_op,
    input  logic            op_32,
    input  logic [XLEN-1:0] operand_a,
    input  logic [XLEN-1:0] operand_b,
    input  mem_kind_t       mem_kind,
    input  mem_size_t       mem_size,
    input  branch_kind_t    branch_kind,
    input  cmp_t            cond,
    input  logic [XLEN-1:0] cmp1,
    input  logic [XLEN-1:0] cmp2,
    input  logic [XLEN-1:0] jump_base,
    input  logic [XLEN-1:0] jump_offset,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] next_pc,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    input  logic            result_valid,
    input  logic [XLEN-1:0] result,
    input  logic            mem_req,
    input  logic            mem_write,
    input  logic [XLEN-1:0] mem_addr,
    input  mem_size_t       mem_size_out,
    input  logic            misaligned,
    output int              result_errs,
    output int              mem_errs,
    output int              flow_errs
);

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] result;
        logic            is_mem;
        logic            write;
        mem_size_t       size;
        logic            mis;
        logic            redirect;
        logic [XLEN-1:0] target;
    } exp_t;

    exp_t pending[$];
    int   squash_left = 0;
    int   n_result = 0;
    int   n_mem = 0;
    int   n_flow = 0;

    assign result_errs = n_result;
    assign mem_errs    = n_mem;
    assign flow_errs   = n_flow;

    function automatic logic [XLEN-1:0] sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // Two's complement order from the sign bits first
    function automatic logic signed_less(input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
        if (x[XLEN-1] != y[XLEN-1])
            return x[XLEN-1];
        return x < y;
    endfunction

    ////////////////////
    // Reference model

    function automatic exp_t expected_outcome(
        input alu_op_t op, input logic op32, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
        input mem_kind_t mk, input mem_size_t ms, input branch_kind_t bk, input cmp_t cnd,
        input logic [XLEN-1:0] c1, input logic [XLEN-1:0] c2, input logic [XLEN-1:0] base,
        input logic [XLEN-1:0] off, input logic [XLEN-1:0] cur_pc,
        input logic [XLEN-1:0] pred_pc);
        exp_t        e;
        logic [31:0] w;
        logic        holds;
        int          bytes;
        e = '0;
        e.valid = 1'b1;
        case (op)
            ALU_ADD:      e.result = op32 ? sext32(a[31:0] + b[31:0]) : a + b;
            ALU_SUB:      e.result = op32 ? sext32(a[31:0] - b[31:0]) : a - b;
            ALU_SLL:      e.result = op32 ? sext32(a[31:0] << b[4:0]) : a << b[5:0];
            ALU_SRL:      e.result = op32 ? sext32(a[31:0] >> b[4:0]) : a >> b[5:0];
            ALU_SRA:
            begin
                // Logical shift, then fill the vacated top bits with the sign
                if (op32)
                begin
                    w = a[31:0] >> b[4:0];
                    if (a[31])
                        w = w | ~(32'hffff_ffff >> b[4:0]);
                    e.result = sext32(w);
                end
                else
                begin
                    e.result = a >> b[5:0];
                    if (a[XLEN-1])
                        e.result = e.result | ~({XLEN{1'b1}} >> b[5:0]);
                end
            end
            ALU_XOR:      e.result = a ^ b;
            ALU_OR:       e.result = a | b;
            ALU_AND:      e.result = a & b;
            ALU_SLT:      e.result = XLEN'(signed_less(a, b));
            ALU_SLTU:     e.result = XLEN'(a < b);
            ALU_PASS_A:   e.result = a;
            ALU_PASS_B:   e.result = b;
            ALU_A_PLUS_4: e.result = a + INSTR_BYTES;
            default:      e.result = '0;
        endcase

        // Misaligned when the last byte lands past the 8-byte line
        e.is_mem = (mk == MEM_LOAD) || (mk == MEM_STORE);
        e.write  = mk == MEM_STORE;
        e.size   = ms;
        bytes    = 1 << ms;
        e.mis    = e.is_mem && (int'(e.result[2:0]) + bytes > 8);

        case (cnd)
            CMP_BEQ:  holds = c1 == c2;
            CMP_BNE:  holds = c1 != c2;
            CMP_BLT:  holds = signed_less(c1, c2);
            CMP_BGE:  holds = !signed_less(c1, c2);
            CMP_BLTU: holds = c1 < c2;
            CMP_BGEU: holds = !(c1 < c2);
            default:  holds = 1'b0;
        endcase
        if (bk == BR_JUMP || (bk == BR_COND && holds))
            e.target = base + off;
        else
            e.target = cur_pc + INSTR_BYTES;
        e.redirect = e.target != pred_pc;
        return e;
    endfunction

    task automatic check_outputs(input exp_t e);
        if (!e.valid)
        begin
            if (result_valid || mem_req || misaligned || redirect)
            begin
                $display("FAILED %0t: strobe high with no operation due (rv %b req %b mis %b rd %b)",
                    $time, result_valid, mem_req, misaligned, redirect);
                n_flow++;
            end
            return;
        end
        if (result_valid !== 1'b1 || result !== e.result)
        begin
            $display("FAILED %0t: result valid %b value %h, expected %h",
                $time, result_valid, result, e.result);
            n_result++;
        end
        if (mem_req !== (e.is_mem && !e.mis) || misaligned !== (e.is_mem && e.mis))
        begin
            $display("FAILED %0t: mem_req %b misaligned %b, expected %b %b",
                $time, mem_req, misaligned, e.is_mem && !e.mis, e.is_mem && e.mis);
            n_mem++;
        end
        else if (mem_req && (mem_addr !== e.result || mem_write !== e.write
                 || mem_size_out !== e.size))
        begin
            $display("FAILED %0t: request addr %h write %b size %0d, expected %h %b %0d",
                $time, mem_addr, mem_write, mem_size_out, e.result, e.write, e.size);
            n_mem++;
        end
        if (redirect !== e.redirect || (e.redirect && redirect_pc !== e.target))
        begin
            $display("FAILED %0t: redirect %b to %h, expected %b to %h",
                $time, redirect, redirect_pc, e.redirect, e.target);
            n_flow++;
        end
    endtask

    ////////////////////
    // Compare two cycles after entry

    always @(posedge CLK)
    begin
        exp_t e;
        if (RST)
        begin
            pending.delete();
            pending.push_back('0);
            pending.push_back('0);
            squash_left = 0;
        end
        else
        begin
            if (pending.size() >= 2)
                check_outputs(pending.pop_front());
            e = '0;
            // Window drops whole cycles, valid or not
            if (squash_left > 0)
                squash_left--;
            else if (in_valid)
            begin
                e = expected_outcome(alu_op, op_32, operand_a, operand_b, mem_kind, mem_size,
                    branch_kind, cond, cmp1, cmp2, jump_base, jump_offset, pc, next_pc);
                if (e.redirect)
                    squash_left = SQUASH_CYCLES;
            end
            pending.push_back(e);
        end
    end

endmodule

// File: verification/tb_ex_stage.sv
`timescale 1ns/10ps

module tb_ex_stage
    import ex_pkg::*;
;

    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS + 20;

    logic            CLK = 1'b0;
    logic            RST;
    logic            in_valid;
    alu_op_t         alu_op;
    logic            op_32;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    mem_kind_t       mem_kind;
    mem_size_t       mem_size;
    branch_kind_t    branch_kind;
    cmp_t            cond;
    logic [XLEN-1:0] cmp1;
    logic [XLEN-1:0] cmp2;
    logic [XLEN-1:0] jump_base;
    logic [XLEN-1:0] jump_offset;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            result_valid;
    logic [XLEN-1:0] result;
    logic            mem_req;
    logic            mem_write;
    logic [XLEN-1:0] mem_addr;
    mem_size_t       mem_size_out;
    logic            misaligned;
    int              result_errs;
    int              mem_errs;
    int              flow_errs;
    logic [63:0]     rng_state = 64'd80909;
    int              cycles = 0;

    always #5 CLK = ~CLK;

    ex_stage u_dut (.*);

    ex_checker u_chk (.*);

    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    task automatic drive_idle();
        in_valid    = 1'b0;
        alu_op      = ALU_ADD;
        op_32       = 1'b0;
        operand_a   = '0;
        operand_b   = '0;
        mem_kind    = MEM_NONE;
        mem_size    = SIZE_BYTE;
        branch_kind = BR_NONE;
        cond        = CMP_BEQ;
        cmp1        = '0;
        cmp2        = '0;
        jump_base   = '0;
        jump_offset = '0;
        pc          = '0;
        next_pc     = INSTR_BYTES;
    endtask

    task automatic drive_random_op();
        logic [63:0]     r;
        logic [2:0]      idx;
        logic [XLEN-1:0] guess;
        r = next_rand();
        in_valid = r[1:0] != 2'b00;
        mem_kind = mem_kind_t'(r[9:8] % 2'd3);
        mem_size = mem_size_t'(r[11:10]);
        // Memory ops form their address with add
        alu_op = (mem_kind != MEM_NONE) ? ALU_ADD : alu_op_t'(r[5:2] % 4'd13);
        op_32  = (mem_kind != MEM_NONE) ? 1'b0 : r[6];
        operand_a = next_rand();
        operand_b = r[7] ? operand_a : next_rand();
        branch_kind = branch_kind_t'(r[13:12] % 2'd3);
        idx  = r[16:14] % 3'd6;
        cond = cmp_t'((idx < 3'd2) ? idx : idx + 3'd2);
        cmp1 = next_rand();
        cmp2 = r[17] ? cmp1 : next_rand();
        jump_base   = next_rand();
        jump_offset = {{52{r[31]}}, r[31:20]};
        pc = next_rand() & ~64'd3;
        // Wrong guess or deliberate offset, right about half the time
        if (branch_kind == BR_JUMP || (branch_kind == BR_COND && r[18]))
            guess = jump_base + jump_offset;
        else
            guess = pc + INSTR_BYTES;
        next_pc = r[19] ? guess : guess + 64'd8;
    endtask

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Stimulus

    initial
    begin
        RST = 1'b1;
        drive_idle();
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        for (int i = 0; i < NUM_OPS; i++)
        begin
            @(negedge CLK);
            drive_random_op();
        end
        @(negedge CLK);
        drive_idle();
        // Let the last two operations leave the pipeline
        repeat (4) @(negedge CLK);
        $display("Errors: result %0d, memory %0d, redirect %0d",
            result_errs, mem_errs, flow_errs);
        if (result_errs + mem_errs + flow_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: files.f
source/ex_pkg.sv
source/ex_alu.sv
source/ex_branch.sv
source/ex_redirect.sv
source/ex_commit.sv
source/ex_stage.sv
verification/ex_checker.sv
verification/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - source/ex_pkg.sv
  - source/ex_alu.sv
  - source/ex_branch.sv
  - source/ex_redirect.sv
  - source/ex_commit.sv
  - source/ex_stage.sv
  - target: test
    files:
      - verification/ex_checker.sv
      - verification/tb_ex_stage.sv
